//--- common/isaPkg.sv
package isaPkg;

  // Instruction field widths
  localparam int opcodeWidth = 6;
  localparam int functWidth  = 6;
  localparam int regIdxWidth = 5;
  localparam int immWidth    = 16;

  // Primary opcodes
  localparam logic [opcodeWidth-1:0] opRType = 6'b000000; // Funct selects the operation
  localparam logic [opcodeWidth-1:0] opBeq   = 6'b000100;
  localparam logic [opcodeWidth-1:0] opBne   = 6'b000101;
  localparam logic [opcodeWidth-1:0] opBle   = 6'b000110;
  localparam logic [opcodeWidth-1:0] opBgt   = 6'b000111;
  localparam logic [opcodeWidth-1:0] opAddi  = 6'b001000;

  // Function codes of R-type instructions
  localparam logic [functWidth-1:0] fnAdd = 6'b100000;
  localparam logic [functWidth-1:0] fnSub = 6'b100010;

  // Register format
  typedef struct packed {
    logic [opcodeWidth-1:0] opcode;
    logic [regIdxWidth-1:0] rs;
    logic [regIdxWidth-1:0] rt;
    logic [regIdxWidth-1:0] rd;
    logic [regIdxWidth-1:0] shamt; // Unused by this instruction set
    logic [functWidth-1:0]  funct;
  } rFields;

  // Immediate format, also used by the branches
  typedef struct packed {
    logic [opcodeWidth-1:0] opcode;
    logic [regIdxWidth-1:0] rs;
    logic [regIdxWidth-1:0] rt;
    logic [immWidth-1:0]    imm;    // Branch offset or ADDI operand
  } iFields;

  // Same 32 bits seen through either format
  // Opcode sits in the same place in both
  typedef union packed {
    rFields rType;
    iFields iType;
  } instrWord;

endpackage

//--- common/ctrlPkg.sv
package ctrlPkg;

  // ALU operation select
  typedef enum logic [2:0] {
    aluNop = 3'd0,
    aluAdd = 3'd1,
    aluSub = 3'd2,
    aluCmp = 3'd7 // Sets eq and gt flags
  } aluOpT;

  // First ALU operand
  typedef enum logic [1:0] {
    srcAPc  = 2'd0,
    srcAReg = 2'd1  // Register A
  } srcAT;

  // Second ALU operand
  typedef enum logic [1:0] {
    srcBReg    = 2'd0, // Register B
    srcBFour   = 2'd1, // Constant 4 for PC increment
    srcBImm    = 2'd2, // Sign extended immediate
    srcBBranch = 2'd3  // Immediate shifted left by two
  } srcBT;

  // Next PC source
  typedef enum logic [1:0] {
    pcSrcNone      = 2'd0,
    pcSrcAluResult = 2'd1,
    pcSrcAluOut    = 2'd2
  } pcSrcT;

  // Register file write address
  typedef enum logic {
    dstRt = 1'b0,
    dstRd = 1'b1
  } regDstT;

  // Instruction class after decode
  typedef enum logic [2:0] {
    opNone, opAdd, opSub, opAddi, opBeq, opBne, opBle, opBgt
  } opKindT;

  typedef enum logic {
    phFetch,
    phExec
  } phaseT;

  // Sequencer step counts
  localparam int stepWidth       = 3;
  localparam int fetchSteps      = 6; // Shared by every instruction
  localparam int aluExecSteps    = 3;
  localparam int branchExecSteps = 4;

endpackage

//--- source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
  import isaPkg::*;
  import ctrlPkg::*;
(
  input  instrWord instr,
  output opKindT   opKind
);

  always_comb begin
    opKind = opNone;

    if (instr.rType.opcode == opRType) begin
      // R-type, the function field picks the operation
      case (instr.rType.funct)
        fnAdd:   opKind = opAdd;
        fnSub:   opKind = opSub;
        default: opKind = opNone;
      endcase
    end else begin
      case (instr.iType.opcode)
        isaPkg::opAddi: opKind = ctrlPkg::opAddi;
        isaPkg::opBeq:  opKind = ctrlPkg::opBeq;
        isaPkg::opBne:  opKind = ctrlPkg::opBne;
        isaPkg::opBle:  opKind = ctrlPkg::opBle; // Taken when not greater
        isaPkg::opBgt:  opKind = ctrlPkg::opBgt;
        default: begin
          opKind = opNone; // Jumps, loads and stores end up here
        end
      endcase
    end
  end

endmodule

//--- control/microSequencer.sv
`timescale 1ns/1ps

module microSequencer
  import ctrlPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  opKindT               opKind,
  output phaseT                phase,
  output logic [stepWidth-1:0] step,
  output opKindT               curOp
);

  logic                 isBranch;
  logic [stepWidth-1:0] lastStep;

  assign isBranch = (curOp == opBeq) || (curOp == opBne) ||
                    (curOp == opBle) || (curOp == opBgt);

  // Final step of the current phase
  always_comb begin
    if (phase == phFetch) begin
      lastStep = stepWidth'(fetchSteps - 1);
    end else if (isBranch) begin
      lastStep = stepWidth'(branchExecSteps - 1);
    end else begin
      lastStep = stepWidth'(aluExecSteps - 1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= phFetch;
      step  <= '0;
      curOp <= opNone;
    end else if (step != lastStep) begin
      step <= step + 1'b1;
    end else if (phase == phFetch) begin
      // Dispatch step, register A and B are loaded by now
      step <= '0;
      if (opKind != opNone) begin
        phase <= phExec;
        curOp <= opKind;
      end
    end else begin
      // Instruction done
      phase <= phFetch;
      step  <= '0;
    end
  end

endmodule

//--- control/controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder
  import ctrlPkg::*;
(
  input  logic                 reset,
  input  phaseT                phase,
  input  logic [stepWidth-1:0] step,
  input  opKindT               curOp,
  input  logic                 eq,
  input  logic                 gt,
  output logic                 pcWrite,
  output logic                 irWrite,
  output logic                 regWrite,
  output logic                 abWrite,
  output logic                 aluOutWrite,
  output aluOpT                aluOp,
  output srcAT                 aluSrcA,
  output srcBT                 aluSrcB,
  output pcSrcT                pcSource,
  output regDstT               regDst
);

  logic isBranch;
  logic branchTaken;

  // Branch condition from the compare flags
  always_comb begin
    isBranch    = 1'b1;
    branchTaken = 1'b0;
    case (curOp)
      opBeq:   branchTaken = eq;
      opBne:   branchTaken = !eq;
      opBle:   branchTaken = !gt;
      opBgt:   branchTaken = gt;
      default: isBranch = 1'b0;
    endcase
  end

  always_comb begin
    pcWrite     = 1'b0;
    irWrite     = 1'b0;
    regWrite    = 1'b0;
    abWrite     = 1'b0;
    aluOutWrite = 1'b0;
    aluOp       = aluNop;
    aluSrcA     = srcAPc;
    aluSrcB     = srcBReg;
    pcSource    = pcSrcNone;
    regDst      = dstRt;

    if (!reset) begin
      if (phase == phFetch) begin
        case (step)
          3'd0, 3'd1, 3'd2: begin
            // PC + 4 while memory read settles
            aluOutWrite = 1'b1;
            aluOp       = aluAdd;
            aluSrcA     = srcAPc;
            aluSrcB     = srcBFour;
            pcSource    = pcSrcAluResult;
          end
          3'd3: begin
            pcWrite  = 1'b1;
            irWrite  = 1'b1; // Instruction register loads here
            pcSource = pcSrcAluOut;
          end
          3'd4: begin
            abWrite = 1'b1;
          end
          default: begin
            // Dispatch step, nothing driven
          end
        endcase
      end else if (isBranch) begin
        case (step)
          3'd0: begin
            // Branch target into ALUOut
            aluOutWrite = 1'b1;
            aluOp       = aluAdd;
            aluSrcA     = srcAPc;
            aluSrcB     = srcBBranch;
          end
          3'd1, 3'd2: begin
            aluOp    = aluCmp;
            aluSrcA  = srcAReg;
            aluSrcB  = srcBReg;
            pcSource = pcSrcAluOut;
            pcWrite  = (step == 3'd2) && branchTaken; // Flags valid one step after compare
          end
          default: begin
          end
        endcase
      end else begin
        case (step)
          3'd0: begin
            aluOutWrite = 1'b1;
            aluOp       = (curOp == opSub) ? aluSub : aluAdd;
            aluSrcA     = srcAReg;
            aluSrcB     = (curOp == opAddi) ? srcBImm : srcBReg;
          end
          3'd1: begin
            regWrite = 1'b1;
            regDst   = (curOp == opAddi) ? dstRt : dstRd; // ADDI writes rt
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

//--- source/ctrlUnitTop.sv
`timescale 1ns/1ps

module ctrlUnitTop
  import isaPkg::*;
  import ctrlPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  instrWord instr,       // From the instruction register
  input  logic     eq,          // ALU compare flags
  input  logic     gt,
  output logic     pcWrite,
  output logic     irWrite,
  output logic     regWrite,
  output logic     abWrite,
  output logic     aluOutWrite,
  output aluOpT    aluOp,
  output srcAT     aluSrcA,
  output srcBT     aluSrcB,
  output pcSrcT    pcSource,
  output regDstT   regDst
);

  opKindT               opKind;
  phaseT                phase;
  logic [stepWidth-1:0] step;
  opKindT               curOp;

  instrDecoder u_instrDecoder (
    .instr  (instr),
    .opKind (opKind)
  );

  microSequencer u_microSequencer (
    .clk    (clk),
    .reset  (reset),
    .opKind (opKind),
    .phase  (phase),
    .step   (step),
    .curOp  (curOp)
  );

  controlEncoder u_controlEncoder (
    .reset       (reset),
    .phase       (phase),
    .step        (step),
    .curOp       (curOp),
    .eq          (eq),
    .gt          (gt),
    .pcWrite     (pcWrite),
    .irWrite     (irWrite),
    .regWrite    (regWrite),
    .abWrite     (abWrite),
    .aluOutWrite (aluOutWrite),
    .aluOp       (aluOp),
    .aluSrcA     (aluSrcA),
    .aluSrcB     (aluSrcB),
    .pcSource    (pcSource),
    .regDst      (regDst)
  );

endmodule

//--- bench/ctrlUnit_sva.sv
`timescale 1ns/1ps

module ctrlUnitSva (
  input logic       clk,
  input logic       reset,
  input logic       pcWrite,
  input logic       irWrite,
  input logic       regWrite,
  input logic       abWrite,
  input logic       aluOutWrite,
  input logic [2:0] aluOp,
  input logic [1:0] aluSrcA,
  input logic [1:0] aluSrcB,
  input logic [1:0] pcSource,
  input logic       regDst
);

  // IR load also advances the PC
  irLoadsPc: assert property (@(posedge clk) disable iff (reset) irWrite |-> pcWrite)
    else $error("irWrite raised without pcWrite");

  noRegAndPc: assert property (@(posedge clk) disable iff (reset) !(regWrite && pcWrite))
    else $error("regWrite and pcWrite high in the same cycle");

  irThenAb: assert property (@(posedge clk) disable iff (reset) irWrite |=> abWrite)
    else $error("abWrite missing one cycle after irWrite");

  quietInReset: assert property (@(posedge clk) reset |-> ({pcWrite, irWrite, regWrite,
      abWrite, aluOutWrite, aluOp, aluSrcA, aluSrcB, pcSource, regDst} == 15'b0))
    else $error("control word not zero during reset");

endmodule

bind ctrlUnitTop ctrlUnitSva u_ctrlUnitSva (.*);

//--- bench/ctrlUnitTb.sv
`timescale 1ns/1ps

module ctrlUnitTb
  import isaPkg::*;
  import ctrlPkg::*;
();

  logic     clk;
  logic     reset;
  instrWord instr;
  logic     eq;
  logic     gt;
  logic     pcWrite;
  logic     irWrite;
  logic     regWrite;
  logic     abWrite;
  logic     aluOutWrite;
  aluOpT    aluOp;
  srcAT     aluSrcA;
  srcBT     aluSrcB;
  pcSrcT    pcSource;
  regDstT   regDst;

  logic [14:0] actualWord;
  integer      seed = 41698;
  string       testName = "reset";
  bit          tbExec;     // Model phase, low in fetch
  int          tbStep;
  bit          aborted;
  int          checkCount;
  int          errorCount;
  int          testsRun;

  ctrlUnitTop u_ctrlUnitTop (.*);

  assign actualWord = {pcWrite, irWrite, regWrite, abWrite, aluOutWrite,
                       aluOp, aluSrcA, aluSrcB, pcSource, regDst};

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic bit isBranchKind(input opKindT kind);
    return kind inside {ctrlPkg::opBeq, ctrlPkg::opBne, ctrlPkg::opBle, ctrlPkg::opBgt};
  endfunction

  function automatic opKindT classify(input instrWord word);
    if (word.rType.opcode == opRType) begin
      if (word.rType.funct == fnAdd) return opAdd;
      if (word.rType.funct == fnSub) return opSub;
      return opNone;
    end
    case (word.iType.opcode)
      isaPkg::opAddi: return ctrlPkg::opAddi;
      isaPkg::opBeq:  return ctrlPkg::opBeq;
      isaPkg::opBne:  return ctrlPkg::opBne;
      isaPkg::opBle:  return ctrlPkg::opBle;
      isaPkg::opBgt:  return ctrlPkg::opBgt;
      default:        return opNone;
    endcase
  endfunction

  // Length of a whole instruction, fetch included
  function automatic int instrCycles(input opKindT kind);
    if (kind == opNone) return 6;
    return isBranchKind(kind) ? 10 : 9;
  endfunction

  // Expected control word for one cycle
  function automatic logic [14:0] expectWord(input instrWord word, input bit exec,
                                             input int step, input logic eqFlag,
                                             input logic gtFlag);
    opKindT kind;
    logic   taken;
    logic   pcW;
    logic   irW;
    logic   regW;
    logic   abW;
    logic   outW;
    aluOpT  op;
    srcAT   srcA;
    srcBT   srcB;
    pcSrcT  pcSel;
    regDstT dst;
    kind  = classify(word);
    taken = (kind == ctrlPkg::opBeq && eqFlag) || (kind == ctrlPkg::opBne && !eqFlag) ||
            (kind == ctrlPkg::opBle && !gtFlag) || (kind == ctrlPkg::opBgt && gtFlag);
    {pcW, irW, regW, abW, outW} = 5'b0;
    op    = aluNop;
    srcA  = srcAPc;
    srcB  = srcBReg;
    pcSel = pcSrcNone;
    dst   = dstRt;
    if (!exec) begin
      if (step <= 2) begin
        outW  = 1'b1; // PC + 4
        op    = aluAdd;
        srcB  = srcBFour;
        pcSel = pcSrcAluResult;
      end else if (step == 3) begin
        pcW   = 1'b1;
        irW   = 1'b1;
        pcSel = pcSrcAluOut;
      end else if (step == 4) begin
        abW = 1'b1;
      end
    end else if (isBranchKind(kind)) begin
      if (step == 0) begin
        outW = 1'b1; // Target address
        op   = aluAdd;
        srcB = srcBBranch;
      end else if (step == 1 || step == 2) begin
        op    = aluCmp;
        srcA  = srcAReg;
        pcSel = pcSrcAluOut;
        pcW   = (step == 2) && taken;
      end
    end else if (step == 0) begin
      outW = 1'b1;
      op   = (kind == opSub) ? aluSub : aluAdd;
      srcA = srcAReg;
      srcB = (kind == ctrlPkg::opAddi) ? srcBImm : srcBReg;
    end else if (step == 1) begin
      regW = 1'b1;
      dst  = (kind == ctrlPkg::opAddi) ? dstRt : dstRd;
    end
    return {pcW, irW, regW, abW, outW, op, srcA, srcB, pcSel, dst};
  endfunction

  function automatic bit listedOpcode(input logic [opcodeWidth-1:0] op);
    return op inside {opRType, isaPkg::opAddi, isaPkg::opBeq, isaPkg::opBne,
                      isaPkg::opBle, isaPkg::opBgt};
  endfunction

  // Random fields, opcode and funct forced by sel
  function automatic instrWord makeInstr(input int sel);
    instrWord word;
    word = $random(seed);
    if (sel <= 1 || sel == 8) word.rType.opcode = opRType;
    case (sel)
      0: word.rType.funct = fnAdd;
      1: word.rType.funct = fnSub;
      2: word.iType.opcode = isaPkg::opAddi;
      3: word.iType.opcode = isaPkg::opBeq;
      4: word.iType.opcode = isaPkg::opBne;
      5: word.iType.opcode = isaPkg::opBle;
      6: word.iType.opcode = isaPkg::opBgt;
      7: begin
        while (listedOpcode(word.iType.opcode)) word.iType.opcode = word.iType.opcode + 6'd1;
      end
      default: begin
        while (word.rType.funct inside {fnAdd, fnSub}) word.rType.funct = word.rType.funct + 6'd1;
      end
    endcase
    return word;
  endfunction

  task automatic randomizeFlags();
    logic [31:0] rnd;
    rnd = $random(seed);
    eq  = rnd[0];
    gt  = rnd[1];
  endtask

  // Starts at the falling edge of fetch step 0, ends at the next one
  task automatic runInstr(input instrWord word);
    int cycles;
    int waited;
    if (aborted) return;
    instr  = word;
    randomizeFlags();
    cycles = 0;
    waited = 0;
    while (!irWrite) begin
      if (waited == 20) begin
        $display("timeout: irWrite did not rise within 20 cycles in test %s", testName);
        aborted = 1'b1;
        return;
      end
      @(negedge clk);
      randomizeFlags();
      cycles++;
      waited++;
    end
    assert (!tbExec && tbStep == 3) else begin
      errorCount++;
      $display("model out of step: irWrite came at model step %0d in test %s", tbStep, testName);
    end
    waited = 0;
    while (aluSrcB != srcBFour) begin // DUT back in fetch once PC + 4 is selected
      if (waited == 20) begin
        $display("timeout: instruction did not return to fetch in test %s", testName);
        aborted = 1'b1;
        return;
      end
      @(negedge clk);
      randomizeFlags();
      cycles++;
      waited++;
    end
    assert (cycles == instrCycles(classify(word))) else begin
      errorCount++;
      $display("error %s: expected %0d cycles, actual %0d", testName,
               instrCycles(classify(word)), cycles);
    end
  endtask

  task automatic runTest(input string name, input int sel, input int count);
    int          errBase;
    int          i;
    logic [31:0] rnd;
    errBase  = errorCount;
    testName = name;
    for (i = 0; i < count; i++) begin
      rnd = $random(seed);
      runInstr(makeInstr(sel < 0 ? int'(rnd % 32'd9) : sel)); // Negative sel mixes all kinds
    end
    testsRun++;
    $display("test %s: %0d instructions, %0d errors", name, count, errorCount - errBase);
  endtask

  always @(posedge clk) begin : compareStep
    logic [14:0] expected;
    expected = reset ? 15'b0 : expectWord(instr, tbExec, tbStep, eq, gt);
    checkCount++;
    assert (actualWord === expected) else begin
      errorCount++;
      $display("error %s: expected %h, actual %h", testName, expected, actualWord);
    end
    if (reset) begin
      tbExec = 1'b0;
      tbStep = 0;
    end else if (!tbExec && tbStep == fetchSteps - 1) begin
      tbExec = (classify(instr) != opNone); // Dispatch or refetch
      tbStep = 0;
    end else if (tbExec && tbStep == (isBranchKind(classify(instr)) ?
                                      branchExecSteps - 1 : aluExecSteps - 1)) begin
      tbExec = 1'b0;
      tbStep = 0;
    end else begin
      tbStep++;
    end
  end

  initial begin
    reset = 1'b1;
    instr = '0;
    eq    = 1'b0;
    gt    = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    testsRun++;
    $display("test reset: %0d errors", errorCount);
    runTest("fetch after reset", 7, 1);
    runTest("add", 0, 4);
    runTest("sub", 1, 4);
    runTest("addi", 2, 4);
    runTest("beq", 3, 6);
    runTest("bne", 4, 6);
    runTest("ble", 5, 6);
    runTest("bgt", 6, 6);
    runTest("unknown opcode", 7, 4);
    runTest("unknown funct", 8, 4);
    runTest("random mix", -1, 200);
    $display("tests %0d, checks %0d, errors %0d", testsRun, checkCount, errorCount);
    if (errorCount == 0 && !aborted) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- project.f
common/isaPkg.sv
common/ctrlPkg.sv
source/instrDecoder.sv
control/microSequencer.sv
control/controlEncoder.sv
source/ctrlUnitTop.sv
bench/ctrlUnit_sva.sv
bench/ctrlUnitTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -f project.f --top-module ctrlUnitTb -o ctrlUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ctrlUnitSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
  echo "Testbench reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
